/* run.sh */
#!/bin/sh
# Build and run the ULA testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module ulaTb \
   -Mdir build \
   -f src.f

./build/VulaTb

/* source/colourEncoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ula_cfg.svh"

module colourEncoder (
   input  wire                    clk7,
   input  wire                    rst_n,
   input  wire ulaPkg::igrbColour pixelColour,
   output ulaPkg::rgb9Colour      rgb
);
   import ulaPkg::*;

   // DAC levels per component
   localparam logic [2:0] LevelOff    = 3'o0;
   localparam logic [2:0] LevelNormal = 3'o5;
   localparam logic [2:0] LevelBright = 3'o7;

   // 16 entry palette, black stays black in both banks
   function automatic rgb9Colour paletteEntry(input igrbColour colour);
      logic [2:0] level;
      level = colour[3] ? LevelBright : LevelNormal;
      return {colour[2] ? level : LevelOff,
              colour[1] ? level : LevelOff,
              colour[0] ? level : LevelOff};
   endfunction

   // Comes out of reset showing the reset border
   always_ff @(posedge clk7) begin
      if (!rst_n)
         rgb <= paletteEntry({1'b0, `ULA_RESET_BORDER});
      else
         rgb <= paletteEntry(pixelColour);
   end

endmodule

`default_nettype wire

/* source/cpuPorts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ula_cfg.svh"

module cpuPorts (
   input  wire                  clk7,
   input  wire                  rst_n,
   input  wire [15:0]           ioAddr,
   input  wire                  ioWrite,
   input  wire                  ioRead,
   input  wire ulaPkg::dataByte cpuDin,
   input  wire [4:0]            kbd,
   input  wire                  ear,
   input  wire                  issue2Keyboard,
   input  wire                  bitmapFetch,
   input  wire                  attrFetch,
   input  wire ulaPkg::dataByte vramData,
   output ulaPkg::dataByte      cpuDout,
   output ulaPkg::borderColour  border,
   output logic                 mic,
   output logic                 spk
);

   // Even address that belongs to another device
   localparam logic [7:0] ExcludedPort = 8'hF4;

   logic evenPort;
   logic earProcessed;

   assign evenPort = !ioAddr[0] && (ioAddr[7:0] != ExcludedPort);

   // Border, MIC and speaker latch
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border <= `ULA_RESET_BORDER;
         mic    <= 1'b0;
         spk    <= 1'b0;
      end else if (ioWrite && evenPort) begin
         border <= cpuDin[2:0];
         mic    <= cpuDin[3];
         spk    <= cpuDin[4];
      end
   end

   // Issue 2 boards also see MIC on the EAR input
   assign earProcessed = issue2Keyboard ? (ear ^ (spk | mic)) : (ear ^ spk);

   always_comb begin
      cpuDout = `ULA_BLANK_BYTE;
      if (ioRead) begin
         if (evenPort)
            cpuDout = {1'b1, earProcessed, 1'b1, kbd};
         // Floating bus shows whatever the video fetch drives
         else if (bitmapFetch || attrFetch)
            cpuDout = vramData;
      end
   end

endmodule

`default_nettype wire

/* source/fetchSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ula_cfg.svh"

module fetchSequencer (
   input  wire                clk7,
   input  wire                rst_n,
   input  wire ulaPkg::hCount hc,
   input  wire ulaPkg::vCount vc,
   output logic               caLoad,
   output logic               bitmapFetch,
   output logic               attrFetch,
   output logic               bitmapLatch,
   output logic               attrLatch,
   output logic               shiftLoad,
   output logic               attrOutLoad,
   output logic               paperEnable
);
   import ulaPkg::*;

   // Output stage runs one cell behind the fetch
   localparam int CellLag = 8;

   typedef enum logic [2:0] {Idle, BitmapAddr, BitmapGrab, AttrAddr, AttrGrab} fetchState;

   fetchState state;
   fetchState nextState;
   hCount     nextHc;
   logic      paperLine;
   logic      slotStart;

   assign nextHc    = hc + hCount'(1);
   assign paperLine = (vc < vCount'(`ULA_PAPER_H));

   // Slots begin at hc 8 and 12 of each 16, inside the paper width
   assign slotStart = paperLine && (nextHc < hCount'(`ULA_PAPER_W))
                      && nextHc[3] && (nextHc[1:0] == 2'd0);

   always_comb begin
      nextState = Idle;
      case (state)
         Idle:       nextState = slotStart ? BitmapAddr : Idle;
         BitmapAddr: nextState = BitmapGrab;
         BitmapGrab: nextState = AttrAddr;
         AttrAddr:   nextState = AttrGrab;
         // Second slot of the pair follows directly
         AttrGrab:   nextState = slotStart ? BitmapAddr : Idle;
         default:    nextState = Idle;
      endcase
   end

   always_ff @(posedge clk7) begin
      if (!rst_n)
         state <= Idle;
      else
         state <= nextState;
   end

   // Address selects and byte captures
   assign bitmapFetch = (state == BitmapAddr) || (state == BitmapGrab);
   assign attrFetch   = (state == AttrAddr) || (state == AttrGrab);
   assign bitmapLatch = (state == BitmapGrab);
   assign attrLatch   = (state == AttrGrab);

   // Per cell strobes
   assign caLoad      = (hc[2:0] == 3'd3);
   assign attrOutLoad = (hc[2:0] == 3'd4);
   assign paperEnable = paperLine && (hc >= hCount'(CellLag))
                        && (hc < hCount'(`ULA_PAPER_W + CellLag));
   assign shiftLoad   = attrOutLoad && paperEnable;

endmodule

`default_nettype wire

/* source/pixelShifter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ula_cfg.svh"

module pixelShifter (
   input  wire                      clk7,
   input  wire                      rst_n,
   input  wire ulaPkg::dataByte     vramData,
   input  wire                      bitmapLatch,
   input  wire                      attrLatch,
   input  wire                      shiftLoad,
   input  wire                      attrOutLoad,
   input  wire                      paperEnable,
   input  wire                      flashPhase,
   input  wire ulaPkg::borderColour border,
   output ulaPkg::igrbColour        pixelColour
);
   import ulaPkg::*;

   dataByte bitmapData;
   dataByte attrData;
   dataByte shifter;
   dataByte attrOut;
   dataByte attrNext;
   logic    inkSelect;

   //////////////////////////////////////////////////////////////////////
   // Fetch side
   //////////////////////////////////////////////////////////////////////

   // Bytes straight off the video bus
   always_ff @(posedge clk7) begin
      if (bitmapLatch)
         bitmapData <= vramData;
      if (attrLatch)
         attrData <= vramData;
   end

   // Outside paper the border becomes paper, ink 0, no bright or flash
   assign attrNext = paperEnable ? attrData : {2'b00, border, 3'b000};

   //////////////////////////////////////////////////////////////////////
   // Output side
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         shifter <= '0;
         attrOut <= {2'b00, `ULA_RESET_BORDER, 3'b000};
      end else begin
         // MSB first, zeros fill in behind
         if (shiftLoad)
            shifter <= bitmapData;
         else
            shifter <= {shifter[6:0], 1'b0};
         // New attribute at every cell boundary
         if (attrOutLoad)
            attrOut <= attrNext;
      end
   end

   // Flashing cells swap ink and paper in the inverted phase
   assign inkSelect = shifter[7] ^ (attrOut[7] & flashPhase);

   // Bright bit shared by ink and paper
   assign pixelColour = inkSelect ? {attrOut[6], attrOut[2:0]}
                                  : {attrOut[6], attrOut[5:3]};

endmodule

`default_nettype wire

/* source/rasterCounter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ula_cfg.svh"

module rasterCounter (
   input  wire           clk7,
   input  wire           rst_n,
   output ulaPkg::hCount hc,
   output ulaPkg::vCount vc,
   output logic          hsync,
   output logic          vsync,
   output logic          intN,
   output logic          flashPhase
);
   import ulaPkg::*;

   logic [`ULA_FLASH_BITS-1:0] flashCount;
   logic lineEnd;
   logic frameEnd;
   logic onVsyncLine;

   assign lineEnd     = (hc == hCount'(`ULA_H_TOTAL - 1));
   assign frameEnd    = (vc == vCount'(`ULA_V_TOTAL - 1));
   assign onVsyncLine = (vc == vCount'(`ULA_VSYNC_LINE));

   // Pixel and line counters
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hc <= '0;
         vc <= '0;
      end else if (lineEnd) begin
         hc <= '0;
         // Line counter wraps at the end of the frame
         if (frameEnd)
            vc <= '0;
         else
            vc <= vc + vCount'(1);
      end else begin
         hc <= hc + hCount'(1);
      end
   end

   // One count per frame, on the first pixel of the vsync line
   always_ff @(posedge clk7) begin
      if (!rst_n)
         flashCount <= '0;
      else if (onVsyncLine && hc == '0)
         flashCount <= flashCount + 1'b1;
   end

   // Toggles every 16 frames
   assign flashPhase = flashCount[`ULA_FLASH_BITS-1];

   // Sync windows straight from the counters
   assign hsync = (hc >= hCount'(`ULA_HSYNC_BEGIN)) && (hc <= hCount'(`ULA_HSYNC_END));
   assign vsync = onVsyncLine;

   // Frame interrupt at the start of the vsync line
   assign intN = !(onVsyncLine && (hc < hCount'(`ULA_INT_CYCLES)));

endmodule

`default_nettype wire

/* source/ulaTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ula_cfg.svh"

module ulaTop (
   input  wire                  clk7,
   input  wire                  rst_n,
   input  wire [15:0]           ioAddr,
   input  wire                  ioWrite,
   input  wire                  ioRead,
   input  wire ulaPkg::dataByte cpuDin,
   input  wire [4:0]            kbd,
   input  wire                  ear,
   input  wire                  issue2Keyboard,
   input  wire ulaPkg::dataByte vramData,
   output ulaPkg::dataByte      cpuDout,
   output ulaPkg::vramAddr      vramAddr,
   output ulaPkg::rgb9Colour    rgb,
   output logic                 hsync,
   output logic                 vsync,
   output logic                 intN,
   output logic                 mic,
   output logic                 spk
);
   import ulaPkg::*;

   //////////////////////////////////////////////////////////////////////
   // Internal nets
   //////////////////////////////////////////////////////////////////////

   hCount       hc;
   vCount       vc;
   logic        flashPhase;
   // Sequencer strobes
   logic        caLoad;
   logic        bitmapFetch;
   logic        attrFetch;
   logic        bitmapLatch;
   logic        attrLatch;
   logic        shiftLoad;
   logic        attrOutLoad;
   logic        paperEnable;
   igrbColour   pixelColour;
   borderColour border;

   //////////////////////////////////////////////////////////////////////
   // Video side
   //////////////////////////////////////////////////////////////////////

   rasterCounter rasterCounter_i (
      .clk7(clk7), .rst_n(rst_n), .hc(hc), .vc(vc),
      .hsync(hsync), .vsync(vsync), .intN(intN), .flashPhase(flashPhase)
   );

   fetchSequencer fetchSequencer_i (
      .clk7(clk7), .rst_n(rst_n), .hc(hc), .vc(vc),
      .caLoad(caLoad), .bitmapFetch(bitmapFetch), .attrFetch(attrFetch),
      .bitmapLatch(bitmapLatch), .attrLatch(attrLatch), .shiftLoad(shiftLoad),
      .attrOutLoad(attrOutLoad), .paperEnable(paperEnable)
   );

   vramAddressGen vramAddressGen_i (
      .clk7(clk7), .rst_n(rst_n), .hc(hc), .vc(vc), .caLoad(caLoad),
      .bitmapFetch(bitmapFetch), .attrFetch(attrFetch), .vramAddr(vramAddr)
   );

   pixelShifter pixelShifter_i (
      .clk7(clk7), .rst_n(rst_n), .vramData(vramData),
      .bitmapLatch(bitmapLatch), .attrLatch(attrLatch), .shiftLoad(shiftLoad),
      .attrOutLoad(attrOutLoad), .paperEnable(paperEnable),
      .flashPhase(flashPhase), .border(border), .pixelColour(pixelColour)
   );

   colourEncoder colourEncoder_i (
      .clk7(clk7), .rst_n(rst_n), .pixelColour(pixelColour), .rgb(rgb)
   );

   // CPU port
   cpuPorts cpuPorts_i (
      .clk7(clk7), .rst_n(rst_n), .ioAddr(ioAddr), .ioWrite(ioWrite),
      .ioRead(ioRead), .cpuDin(cpuDin), .kbd(kbd), .ear(ear),
      .issue2Keyboard(issue2Keyboard), .bitmapFetch(bitmapFetch),
      .attrFetch(attrFetch), .vramData(vramData), .cpuDout(cpuDout),
      .border(border), .mic(mic), .spk(spk)
   );

endmodule

`default_nettype wire

/* source/ula_cfg.svh */
`ifndef ULA_CFG_SVH
`define ULA_CFG_SVH

// Raster geometry in 7 MHz pixel clocks and lines
`define ULA_H_TOTAL 448
`define ULA_V_TOTAL 312

// Paper window, top left corner at hc 0 and vc 0
`define ULA_PAPER_W 256
`define ULA_PAPER_H 192

// Cycles from hc = x until pixel x shows on rgb
`define ULA_PIXEL_DELAY 14

// Sync and interrupt timing
`define ULA_HSYNC_BEGIN 344
`define ULA_HSYNC_END 375
`define ULA_VSYNC_LINE 248
`define ULA_INT_CYCLES 32

// Flash counter, top bit is the flash phase
`define ULA_FLASH_BITS 5

// Port values
`define ULA_RESET_BORDER 3'd2
`define ULA_BLANK_BYTE 8'hFF

`endif

/* source/ula_pkg.sv */
`default_nettype none

package ulaPkg;

   // Raster position
   typedef logic [8:0] hCount;
   typedef logic [8:0] vCount;

   // 16 KB video memory address
   typedef logic [13:0] vramAddr;

   // Byte from video memory or the CPU data bus
   typedef logic [7:0] dataByte;

   // Bright bit on top, then G, R, B
   typedef logic [3:0] igrbColour;

   // GGG RRR BBB for the video DAC
   typedef logic [8:0] rgb9Colour;

   // Border index from the port write, G R B
   typedef logic [2:0] borderColour;

endpackage

`default_nettype wire

/* source/vramAddressGen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ula_cfg.svh"

module vramAddressGen (
   input  wire                clk7,
   input  wire                rst_n,
   input  wire ulaPkg::hCount hc,
   input  wire ulaPkg::vCount vc,
   input  wire                caLoad,
   input  wire                bitmapFetch,
   input  wire                attrFetch,
   output ulaPkg::vramAddr    vramAddr
);

   // Attribute area starts at 0x1800
   localparam logic [2:0] AttrPrefix = 3'b110;

   logic [4:0] column;

   // Character column, taken a few cycles ahead of the slot
   always_ff @(posedge clk7) begin
      if (!rst_n)
         column <= '0;
      else if (caLoad)
         column <= hc[7:3];
   end

   always_comb begin
      // Idle bus reads as zero
      vramAddr = '0;
      if (bitmapFetch)
         // Thirds, then pixel row, then character row
         vramAddr = {1'b0, vc[7:6], vc[2:0], vc[5:3], column};
      else if (attrFetch)
         vramAddr = {1'b0, AttrPrefix, vc[7:3], column};
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/ula_pkg.sv
source/rasterCounter.sv
source/fetchSequencer.sv
source/vramAddressGen.sv
source/pixelShifter.sv
source/colourEncoder.sv
source/cpuPorts.sv
source/ulaTop.sv
verif/ula_assertions.sv
verif/ulaTb.sv

/* verif/ulaTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ula_cfg.svh"

module ulaTb;
   import ulaPkg::*;

   localparam int FrameCycles = `ULA_H_TOTAL * `ULA_V_TOTAL;
   // Two flash periods of 16 frames
   localparam int RunFrames   = 32;
   localparam int CycleLimit  = 40 * FrameCycles;

   logic        clk7;
   logic        rst_n;
   logic [15:0] ioAddr;
   logic        ioWrite;
   logic        ioRead;
   dataByte     cpuDin;
   logic [4:0]  kbd;
   logic        ear;
   logic        issue2Keyboard;
   dataByte     vramData;
   dataByte     cpuDout;
   vramAddr     vramAddress;
   rgb9Colour   rgb;
   logic        hsync;
   logic        vsync;
   logic        intN;
   logic        mic;
   logic        spk;

   // 16 KB video RAM with asynchronous read
   dataByte vram [0:16383];

   // Reference model state, hc and vc of the current cycle
   hCount       tbHc;
   vCount       tbVc;
   int          tbFrame;
   borderColour expBorder;
   logic        expMic;
   logic        expSpk;
   logic        borderHold;
   logic        running;
   int          cycleCount;
   // Stimulus coverage
   int          portReads;
   int          busReads;
   int          flashPixels;

   ulaTop ulaTop_i (
      .clk7(clk7), .rst_n(rst_n), .ioAddr(ioAddr), .ioWrite(ioWrite), .ioRead(ioRead),
      .cpuDin(cpuDin), .kbd(kbd), .ear(ear), .issue2Keyboard(issue2Keyboard),
      .vramData(vramData), .cpuDout(cpuDout), .vramAddr(vramAddress), .rgb(rgb),
      .hsync(hsync), .vsync(vsync), .intN(intN), .mic(mic), .spk(spk)
   );

   assign vramData = vram[vramAddress];

   initial begin
      clk7 = 1'b0;
      forever #5 clk7 = ~clk7;
   end

   //////////////////////////////////////////////////////////////////////
   // Reference functions
   //////////////////////////////////////////////////////////////////////

   // Each component off, 5 or 7 when bright
   function automatic rgb9Colour paletteValue(input igrbColour c);
      logic [2:0] level;
      logic [2:0] g;
      logic [2:0] r;
      logic [2:0] b;
      level = c[3] ? 3'o7 : 3'o5;
      g     = c[2] ? level : 3'o0;
      r     = c[1] ? level : 3'o0;
      b     = c[0] ? level : 3'o0;
      return {g, r, b};
   endfunction

   // Thirds of 2 KB, pixel rows of 256 bytes, character rows of 32, column
   function automatic vramAddr bitmapAddress(input logic [4:0] col, input vCount v);
      return vramAddr'(2048 * int'(v[7:6]) + 256 * int'(v[2:0])
                       + 32 * int'(v[5:3]) + int'(col));
   endfunction

   // 32 attributes per character row from 0x1800
   function automatic vramAddr attrAddress(input logic [4:0] col, input vCount v);
      return vramAddr'(6144 + 32 * int'(v[7:3]) + int'(col));
   endfunction

   function automatic logic onPaper(input hCount h, input vCount v);
      return int'(v) < `ULA_PAPER_H && int'(h) >= `ULA_PIXEL_DELAY
             && int'(h) < `ULA_PAPER_W + `ULA_PIXEL_DELAY;
   endfunction

   // Fetch slots cover hc 8 to 15 of every 16 inside the paper width
   function automatic logic fetchCycle(input hCount h, input vCount v);
      return int'(v) < `ULA_PAPER_H && int'(h) >= 8 && int'(h) < `ULA_PAPER_W && h[3];
   endfunction

   function automatic logic flashingCell(input hCount h, input vCount v);
      return vram[attrAddress(5'((int'(h) - `ULA_PIXEL_DELAY) / 8), v)][7];
   endfunction

   function automatic rgb9Colour expectedRgb(input hCount h, input vCount v,
                                             input logic phase, input borderColour b);
      int         x;
      logic [4:0] col;
      dataByte    bits;
      dataByte    attr;
      logic       ink;
      if (!onPaper(h, v))
         return paletteValue({1'b0, b});
      x    = int'(h) - `ULA_PIXEL_DELAY;
      col  = 5'(x / 8);
      // Leftmost pixel is the top bit
      bits = vram[bitmapAddress(col, v)] << (x % 8);
      attr = vram[attrAddress(col, v)];
      ink  = bits[7] ^ (attr[7] & phase);
      return paletteValue(ink ? {attr[6], attr[2:0]} : {attr[6], attr[5:3]});
   endfunction

   // hsync, vsync, intN
   function automatic logic [2:0] syncLevels(input hCount h, input vCount v);
      logic hs;
      logic vs;
      hs = int'(h) >= `ULA_HSYNC_BEGIN && int'(h) <= `ULA_HSYNC_END;
      vs = int'(v) == `ULA_VSYNC_LINE;
      return {hs, vs, !(vs && int'(h) < `ULA_INT_CYCLES)};
   endfunction

   function automatic logic evenPort(input logic [15:0] a);
      return !a[0] && a[7:0] != 8'hF4;
   endfunction

   function automatic dataByte portByte(input logic e, input logic issue2,
                                        input logic [4:0] keys, input logic m, input logic s);
      logic earBit;
      earBit = issue2 ? e ^ (s | m) : e ^ s;
      return {1'b1, earBit, 1'b1, keys};
   endfunction

   // Video bus address, zero between fetches
   function automatic vramAddr expectedAddress(input hCount h, input vCount v);
      logic [4:0] col;
      if (!fetchCycle(h, v))
         return '0;
      // Column register trails hc by half a cell
      col = 5'((int'(h) - 4) / 8);
      // First two cycles of a slot address the bitmap
      if (!h[1])
         return bitmapAddress(col, v);
      return attrAddress(col, v);
   endfunction

   function automatic dataByte floatingByte(input hCount h, input vCount v);
      if (!fetchCycle(h, v))
         return `ULA_BLANK_BYTE;
      return vram[expectedAddress(h, v)];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic abortRun(input string reason);
      $display("Some tests failed");
      $fatal(1, "%s", reason);
   endtask

   task automatic checkColour(input string what, input rgb9Colour got, input rgb9Colour exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %o, expected %o (hc %0d, line %0d, frame %0d)",
                  $time, what, got, exp, tbHc, tbVc, tbFrame);
         abortRun("Video output did not match the reference model");
      end
   endtask

   task automatic checkByte(input string what, input dataByte got, input dataByte exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %h, expected %h (hc %0d, line %0d, port %h)",
                  $time, what, got, exp, tbHc, tbVc, ioAddr);
         abortRun("Port read did not match the reference model");
      end
   endtask

   task automatic checkAddress(input string what, input vramAddr got, input vramAddr exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %h, expected %h (hc %0d, line %0d)",
                  $time, what, got, exp, tbHc, tbVc);
         abortRun("Video memory address did not match the reference model");
      end
   endtask

   task automatic checkBit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %b, expected %b (hc %0d, line %0d)",
                  $time, what, got, exp, tbHc, tbVc);
         abortRun("Control output did not match the reference model");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic fillVram();
      for (int i = 0; i < 16384; i++)
         vram[vramAddr'(i)] = dataByte'($urandom);
      // One attribute in four flashes
      for (int i = 6144; i < 6912; i++)
         vram[vramAddr'(i)][7] = ($urandom_range(3) == 0);
   endtask

   // Inputs for the cycle that starts at this edge
   task automatic driveCycle();
      logic [15:0] addr;
      addr    = 16'($urandom);
      ioWrite <= 1'b0;
      ioRead  <= 1'b0;
      if (int'(tbHc) == 300 && $urandom_range(15) == 0) begin
         // Mid line, so the new border is settled by the next line
         ioAddr  <= addr & 16'hFFFE;
         cpuDin  <= dataByte'($urandom);
         ioWrite <= 1'b1;
      end else if ($urandom_range(31) == 0) begin
         ioAddr         <= ($urandom_range(1) == 0) ? addr & 16'hFFFE : addr | 16'h0001;
         kbd            <= 5'($urandom);
         ear            <= 1'($urandom);
         issue2Keyboard <= 1'($urandom);
         ioRead         <= 1'b1;
      end
   endtask

   initial begin
      void'($urandom(32'h4e21_b4f9));
      fillVram();
      rst_n          = 1'b0;
      ioAddr         = '0;
      ioWrite        = 1'b0;
      ioRead         = 1'b0;
      cpuDin         = '0;
      kbd            = 5'h1F;
      ear            = 1'b0;
      issue2Keyboard = 1'b0;
      tbHc           = '0;
      tbVc           = '0;
      tbFrame        = 0;
      expBorder      = `ULA_RESET_BORDER;
      expMic         = 1'b0;
      expSpk         = 1'b0;
      borderHold     = 1'b0;
      running        = 1'b0;
      cycleCount     = 0;
      portReads      = 0;
      busReads       = 0;
      flashPixels    = 0;
      repeat (2) @(posedge clk7);
      rst_n   <= 1'b1;
      running <= 1'b1;
      while (tbFrame < RunFrames) begin
         @(posedge clk7);
         driveCycle();
      end
      if (portReads > 0 && busReads > 0 && flashPixels > 0) begin
         $display("All tests passed");
         $finish;
      end else begin
         abortRun("Run ended without port reads, fetch reads or flashing pixels");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Compare and model update, mid cycle
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk7) begin
      logic [2:0] syncExp;
      dataByte    doutExp;
      logic       paper;
      if (running) begin
         syncExp = syncLevels(tbHc, tbVc);
         checkBit("hsync", hsync, syncExp[2]);
         checkBit("vsync", vsync, syncExp[1]);
         checkBit("intN", intN, syncExp[0]);
         checkAddress("vramAddr", vramAddress, expectedAddress(tbHc, tbVc));
         // Border positions skipped for the rest of a write line
         paper = onPaper(tbHc, tbVc);
         if (paper || !borderHold)
            checkColour("rgb", rgb, expectedRgb(tbHc, tbVc, tbFrame[4], expBorder));
         if (paper && tbFrame[4] && flashingCell(tbHc, tbVc))
            flashPixels++;
         if (!ioRead) begin
            doutExp = `ULA_BLANK_BYTE;
         end else if (evenPort(ioAddr)) begin
            doutExp = portByte(ear, issue2Keyboard, kbd, expMic, expSpk);
            portReads++;
         end else begin
            doutExp = floatingByte(tbHc, tbVc);
            if (fetchCycle(tbHc, tbVc))
               busReads++;
         end
         checkByte("cpuDout", cpuDout, doutExp);
         checkBit("mic", mic, expMic);
         checkBit("spk", spk, expSpk);
         // Port latch takes effect at the end of the write cycle
         if (ioWrite && evenPort(ioAddr)) begin
            expBorder  = cpuDin[2:0];
            expMic     = cpuDin[3];
            expSpk     = cpuDin[4];
            borderHold = 1'b1;
         end
         if (int'(tbHc) == `ULA_H_TOTAL - 1) begin
            tbHc       = '0;
            borderHold = 1'b0;
            if (int'(tbVc) == `ULA_V_TOTAL - 1) begin
               tbVc    = '0;
               tbFrame = tbFrame + 1;
            end else begin
               tbVc = tbVc + vCount'(1);
            end
         end else begin
            tbHc = tbHc + hCount'(1);
         end
      end
   end

   // Run limit
   always @(posedge clk7) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount > CycleLimit)
         abortRun("Timeout, the run went past 40 frames of clock cycles");
   end

endmodule

`default_nettype wire

/* verif/ula_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module ulaAssertions (
   input wire clk7,
   input wire rst_n,
   input wire bitmapFetch,
   input wire attrFetch,
   input wire shiftLoad,
   input wire attrOutLoad,
   input wire intN,
   input wire vsync
);

   // One video bus, one select at a time
   fetchExclusive: assert property (@(posedge clk7) disable iff (!rst_n)
      !(bitmapFetch && attrFetch))
      else $error("bitmapFetch and attrFetch high in the same cycle");

   // Shift loads sit on the cell boundary
   loadOnBoundary: assert property (@(posedge clk7) disable iff (!rst_n)
      shiftLoad |-> attrOutLoad)
      else $error("shiftLoad without attrOutLoad");

   // Frame interrupt only on the vsync line
   intInsideVsync: assert property (@(posedge clk7) disable iff (!rst_n)
      !intN |-> vsync)
      else $error("intN low outside vsync");

endmodule

bind ulaTop ulaAssertions ulaAssertions_i (
   .clk7(clk7), .rst_n(rst_n), .bitmapFetch(bitmapFetch), .attrFetch(attrFetch),
   .shiftLoad(shiftLoad), .attrOutLoad(attrOutLoad), .intN(intN), .vsync(vsync)
);

`default_nettype wire
